// File: Bender.yml
package:
  name: nd_cpu_slice

sources:
  - nd_cs_pkg.sv
  - nd_bus_pkg.sv
  - cpu_seq.sv
  - cpu_cs.sv
  - cpu_alu.sv
  - cpu_mmu.sv
  - cpu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_cpu.sv

// File: cpu_alu.sv
/*
  16-bit datapath: 8 x 16 register file, ALU and flag register.
  Decodes the ALU form of the microword and issues the bus and MMU
  strobes; a jump word or a halted sequencer changes nothing.
*/
`timescale 1ns/1ps

module cpu_alu
  import nd_cs_pkg::*;
  import nd_bus_pkg::*;
(
  input  logic       sysclk,
  input  logic       arst_n,
  input  cs_word_t   cs_word,
  input  logic       run,     // Sequencer running
  input  cpu_word_t  idb,     // Internal data bus
  output cpu_word_t  result,  // Value driven onto the IDB
  output cpu_word_t  a_val,
  output cpu_word_t  b_val,
  output alu_flags_t flags,
  output logic       stoc,
  output logic       map,
  output logic       wpt
);

  alu_fmt_t  aw;
  logic      exec;     // ALU word in a running cycle
  cpu_word_t core;     // Operation result from A and B
  logic      carry_n;  // Next carry
  cpu_word_t wr_data;  // Register and flag source
  cpu_word_t rf [8];

  assign aw   = cs_word.alu;
  assign exec = run & ~aw.fmt;

  // Operand read
  assign a_val = rf[aw.src_a];
  assign b_val = aw.use_imm ? {4'b0, aw.imm} : rf[aw.src_b];  // Zero-extended immediate

  always_comb begin
    carry_n = 1'b0;  // Only add, sub and shl set carry
    core    = '0;
    case (aw.op)
      op_add:    {carry_n, core} = {1'b0, a_val} + {1'b0, b_val};
      op_sub:    {carry_n, core} = {1'b0, a_val} - {1'b0, b_val};  // Carry is borrow
      op_and:    core = a_val & b_val;
      op_or:     core = a_val | b_val;
      op_xor:    core = a_val ^ b_val;
      op_pass_b: core = b_val;
      op_shl:    {carry_n, core} = {a_val, 1'b0};  // MSB out to carry
      default:   core = '0;  // ld_idb takes the bus below
    endcase
  end

  // On ld_idb the ALU listens to the bus and drives nothing onto it
  assign wr_data = (aw.op == op_ld_idb) ? idb : core;
  assign result  = (aw.op == op_ld_idb) ? '0 : core;

  // Strobes only from a running ALU word
  assign stoc = exec & aw.stoc;
  assign map  = exec & aw.map;
  assign wpt  = exec & aw.wpt;

  // Register write at end of cycle
  always_ff @(posedge sysclk) begin
    if (exec && aw.wr_en) begin
      rf[aw.dst] <= wr_data;
    end
  end

  // Flags follow every executed ALU word
  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      flags <= '0;
    end else if (exec) begin
      flags.zero  <= (wr_data == '0);
      flags.carry <= carry_n;
    end
  end

endmodule

// File: cpu_cs.sv
/*
  Writable control store, 2^CS_AW microwords of 32 bits.
  Loaded through the active-low write strobe while the sequencer
  is halted; the read follows the micro-PC without a clock.
*/
`timescale 1ns/1ps

module cpu_cs
  import nd_cs_pkg::*;
#(
  parameter int CS_AW = 8
) (
  input  logic             sysclk,
  input  logic [CS_AW-1:0] upc,       // Read address
  input  logic             wcs_n,     // Write strobe, active low
  input  logic [CS_AW-1:0] cs_waddr,
  input  cs_word_t         cs_wdata,
  output cs_word_t         cs_word    // Current microword
);

  localparam int depth = 2 ** CS_AW;

  cs_word_t mem [depth];

  // Write on the rising edge, readable next cycle
  always_ff @(posedge sysclk) begin
    if (!wcs_n) begin
      mem[cs_waddr] <= cs_wdata;
    end
  end

  // Asynchronous read
  assign cs_word = mem[upc];

endmodule

// File: cpu_mmu.sv
/*
  Memory management. A 64-entry page table loaded by microcode, a
  translation register for the physical address and fault detection.
  A map gives lapa or trap for exactly one cycle after it is issued.
*/
`timescale 1ns/1ps

module cpu_mmu
  import nd_bus_pkg::*;
(
  input  logic      sysclk,
  input  logic      arst_n,
  input  logic      map,    // Translate a_val
  input  logic      wpt,    // Write entry [a_val page] with b_val
  input  cpu_word_t a_val,
  input  cpu_word_t b_val,
  output pa_t       pa,
  output logic      lapa,   // Translation present
  output logic      trap    // Page fault
);

  log_addr_t   la;
  pte_t        wr_pte;
  pte_t        rd_pte;
  logic [13:0] pt_ppn [64];  // Page numbers, no reset
  logic [63:0] pt_valid;     // Valid bits, cleared by reset

  assign la     = log_addr_t'(a_val);
  assign wr_pte = pte_t'(b_val);

  // Old entry seen if map and wpt share a cycle
  assign rd_pte = '{valid: pt_valid[la.page], spare: 1'b0, ppn: pt_ppn[la.page]};

  always_ff @(posedge sysclk) begin
    if (wpt) begin
      pt_ppn[la.page] <= wr_pte.ppn;
    end
  end

  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      pt_valid <= '0;
    end else if (wpt) begin
      pt_valid[la.page] <= wr_pte.valid;
    end
  end

  // Translation register
  always_ff @(posedge sysclk) begin
    if (map) begin
      pa <= '{ppn: rd_pte.ppn, offset: la.offset};
    end
  end

  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      lapa <= 1'b0;
      trap <= 1'b0;
    end else begin
      lapa <= map & rd_pte.valid;   // One cycle only
      trap <= map & ~rd_pte.valid;  // Invalid page
    end
  end

endmodule

// File: cpu_seq.sv
/*
  Microsequencer. Steps the micro-PC one word per cycle, takes jumps on
  the ALU flags, halts on a stop word and restarts at 0 on fetch.
  A page fault vectors to the top control store word.
*/
`timescale 1ns/1ps

module cpu_seq
  import nd_cs_pkg::*;
#(
  parameter int CS_AW = 8  // Control store address width, max 12
) (
  input  logic             sysclk,
  input  logic             arst_n,
  input  cs_word_t         cs_word,
  input  alu_flags_t       flags,
  input  logic             trap,    // Page fault from the MMU
  input  logic             fetch,   // Restart strobe
  output logic [CS_AW-1:0] upc,
  output logic             run,
  output logic             halt
);

  localparam logic [CS_AW-1:0] trap_vec = '1;  // Highest word

  jmp_fmt_t jw;
  logic     is_jmp;
  logic     cond_ok;
  logic     stop;
  logic     take;

  assign jw     = cs_word.jmp;
  assign is_jmp = jw.fmt;
  assign run    = ~halt;

  // Condition against the flags of the last executed ALU word
  always_comb begin
    case (jw.cond)
      cond_always: cond_ok = 1'b1;
      cond_zero:   cond_ok = flags.zero;
      cond_nzero:  cond_ok = ~flags.zero;
      cond_carry:  cond_ok = flags.carry;
      default:     cond_ok = 1'b0;  // Stop and unused codes
    endcase
  end

  assign stop = run & is_jmp & (jw.cond == cond_stop);
  assign take = run & is_jmp & cond_ok;

  always_ff @(posedge sysclk or negedge arst_n) begin
    if (!arst_n) begin
      upc  <= '0;
      halt <= 1'b1;  // Wait for the first fetch
    end else if (fetch) begin
      upc  <= '0;    // Restart at word 0
      halt <= 1'b0;
    end else if (trap) begin
      upc <= trap_vec;  // Fault handler
    end else if (halt) begin
      upc <= upc;       // Frozen
    end else if (stop) begin
      halt <= 1'b1;     // upc holds on the stop word
    end else if (take) begin
      upc <= jw.target[CS_AW-1:0];
    end else begin
      upc <= upc + 1'b1;
    end
  end

endmodule

// File: cpu_top.sv
/*
  CPU slice top level. Connects sequencer, control store, ALU and MMU,
  forms the IDB as a wired-OR of the ALU and the external input, and
  gates CD and the physical page onto the outputs by stoc and lapa.
*/
`timescale 1ns/1ps

module cpu_top
  import nd_cs_pkg::*;
  import nd_bus_pkg::*;
#(
  parameter int CS_AW = 8  // Control store address width, max 12
) (
  input  logic             sysclk,
  input  logic             arst_n,
  input  logic             wcs_n,     // Control store write, active low
  input  logic [CS_AW-1:0] cs_waddr,
  input  cs_word_t         cs_wdata,
  input  logic             fetch,     // Start or restart at word 0
  input  cpu_word_t        idb_in,    // External IDB source
  output cpu_word_t        cd_out,
  output logic             stoc,
  output pa_t              ppn_out,
  output logic             lapa,
  output logic             trap,
  output logic             halt
);

  logic [CS_AW-1:0] upc;
  cs_word_t         cs_word;
  logic             run;
  alu_flags_t       flags;
  cpu_word_t        result;
  cpu_word_t        a_val;
  cpu_word_t        b_val;
  cpu_word_t        idb;
  logic             map;
  logic             wpt;
  pa_t              pa;

  cpu_seq #(.CS_AW(CS_AW)) seq (
    .sysclk (sysclk),
    .arst_n (arst_n),
    .cs_word(cs_word),
    .flags  (flags),
    .trap   (trap),
    .fetch  (fetch),
    .upc    (upc),
    .run    (run),
    .halt   (halt)
  );

  cpu_cs #(.CS_AW(CS_AW)) cs (
    .sysclk  (sysclk),
    .upc     (upc),
    .wcs_n   (wcs_n),
    .cs_waddr(cs_waddr),
    .cs_wdata(cs_wdata),
    .cs_word (cs_word)
  );

  cpu_alu alu (
    .sysclk (sysclk),
    .arst_n (arst_n),
    .cs_word(cs_word),
    .run    (run),
    .idb    (idb),      // ld_idb source
    .result (result),
    .a_val  (a_val),
    .b_val  (b_val),
    .flags  (flags),
    .stoc   (stoc),
    .map    (map),
    .wpt    (wpt)
  );

  cpu_mmu mmu (
    .sysclk(sysclk),
    .arst_n(arst_n),
    .map   (map),
    .wpt   (wpt),
    .a_val (a_val),
    .b_val (b_val),
    .pa    (pa),
    .lapa  (lapa),
    .trap  (trap)
  );

  // Wired-OR bus, ALU drives only on stoc
  assign idb = (stoc ? result : '0) | idb_in;

  // Open-collector style output stages read as zero when off
  assign cd_out  = stoc ? idb : '0;
  assign ppn_out = lapa ? pa : '0;

endmodule

// File: flist.f
+incdir+.
nd_cs_pkg.sv
nd_bus_pkg.sv
cpu_seq.sv
cpu_cs.sv
cpu_alu.sv
cpu_mmu.sv
cpu_top.sv
tb_cpu.sv

// File: nd_bus_pkg.sv
/*
  Bus word and memory-management types.
  A 16-bit logical address splits into a 6-bit page table index (15:10)
  and a 10-bit offset (9:0); the physical address is ppn plus offset.
*/
package nd_bus_pkg;

  typedef logic [15:0] cpu_word_t;

  // Page table entry as written from a bus word
  typedef struct packed {
    logic        valid;  // Bit 15
    logic        spare;  // Bit 14, ignored
    logic [13:0] ppn;
  } pte_t;

  // 24-bit physical address
  typedef struct packed {
    logic [13:0] ppn;
    logic [9:0]  offset;
  } pa_t;

  // Logical address split, upper 6 bits index the page table
  typedef struct packed {
    logic [5:0] page;
    logic [9:0] offset;
  } log_addr_t;

endpackage

// File: nd_cs_pkg.sv
/*
  Microinstruction formats for the control store, shared by the
  microsequencer, the ALU datapath and the testbench model.
  One 32-bit word is read either as an ALU operation or as a jump.
*/
package nd_cs_pkg;

  typedef enum logic [2:0] {
    op_add    = 3'd0,
    op_sub    = 3'd1,
    op_and    = 3'd2,
    op_or     = 3'd3,
    op_xor    = 3'd4,
    op_pass_b = 3'd5,
    op_shl    = 3'd6,
    op_ld_idb = 3'd7   // Register takes the IDB
  } alu_op_e;

  typedef enum logic [2:0] {
    cond_always = 3'd0,
    cond_zero   = 3'd1,
    cond_nzero  = 3'd2,
    cond_carry  = 3'd3,
    cond_stop   = 3'd4  // Halt until fetch
  } cond_e;

  // ALU format, format bit low
  typedef struct packed {
    logic        fmt;      // 0 for ALU word
    alu_op_e     op;
    logic [2:0]  dst;
    logic [2:0]  src_a;
    logic [2:0]  src_b;
    logic        use_imm;  // B from immediate
    logic [11:0] imm;
    logic        wr_en;    // Write dst
    logic        stoc;     // Result onto IDB and CD
    logic        map;      // Translate src_a
    logic        wpt;      // Page table entry [src_a] <= src_b
    logic [1:0]  spare;
  } alu_fmt_t;

  // Jump format, format bit high
  typedef struct packed {
    logic        fmt;      // 1 for jump word
    cond_e       cond;
    logic [11:0] target;
    logic [15:0] spare;
  } jmp_fmt_t;

  typedef union packed {
    alu_fmt_t alu;
    jmp_fmt_t jmp;
  } cs_word_t;

  typedef struct packed {
    logic zero;
    logic carry;
  } alu_flags_t;

endpackage

// File: tb_cpu_model.svh
/*
  Reference model of the CPU slice, included inside the testbench module.
  Runs the loaded microprogram from the control store image and queues the
  expected CD words in order, and each translation and trap with its cycle.
*/
`ifndef TB_CPU_MODEL_SVH
`define TB_CPU_MODEL_SVH

cs_word_t    cs_img [256];         // Copy of everything written to the store
cpu_word_t   m_rf [8];             // Register file copy
alu_flags_t  m_flags;
logic [13:0] m_ppn [64];
logic [63:0] m_valid;              // Cleared with the DUT reset
cpu_word_t   cd_q [$];             // Expected CD words
pa_t         pa_q [$];             // Expected translations
int          pa_cyc_q [$];         // Cycle after fetch of each translation
int          trap_q [$];           // Cycle after fetch of each trap

// Runs from word 0 until the stop word and returns the number of cycles
function automatic int model_run(input cpu_word_t idb_v);
  logic [7:0] upc;
  cs_word_t   w;
  cpu_word_t  a, b, res, bus, wr;
  logic       cy, pend_lapa, pend_trap, trap_now, ok;
  pa_t        pend_pa;
  int         n;
  upc = '0;
  pend_lapa = 1'b0;
  pend_trap = 1'b0;
  pend_pa = '0;
  for (n = 1; n < 2000; n++) begin
    w = cs_img[upc];                           // Cycle n runs this word
    trap_now = pend_trap;                      // Fault from the map one cycle back
    if (pend_lapa) begin
      pa_q.push_back(pend_pa);
      pa_cyc_q.push_back(n);
    end
    if (pend_trap) trap_q.push_back(n);
    pend_lapa = 1'b0;
    pend_trap = 1'b0;
    if (!w.alu.fmt) begin
      a = m_rf[w.alu.src_a];
      b = w.alu.use_imm ? cpu_word_t'(w.alu.imm) : m_rf[w.alu.src_b];
      cy = 1'b0;
      case (w.alu.op)
        op_add:    {cy, res} = a + b + 17'd0;
        op_sub: begin
          res = a - b;
          cy  = (b > a);                         // Borrow
        end
        op_and:    res = a & b;
        op_or:     res = a | b;
        op_xor:    res = a ^ b;
        op_pass_b: res = b;
        op_shl: begin
          res = a << 1;
          cy  = a[15];                           // MSB shifted out
        end
        default:   res = '0;                     // ld_idb leaves the bus alone
      endcase
      bus = (w.alu.stoc ? res : 16'h0) | idb_v;   // Wired-OR with the external input
      wr  = (w.alu.op == op_ld_idb) ? bus : res;
      if (w.alu.stoc) cd_q.push_back(bus);
      if (w.alu.map) begin
        pend_lapa = m_valid[a[15:10]];
        pend_trap = !m_valid[a[15:10]];
        pend_pa   = '{ppn: m_ppn[a[15:10]], offset: a[9:0]};
      end
      if (w.alu.wpt) begin
        m_valid[a[15:10]] = b[15];
        m_ppn[a[15:10]]   = b[13:0];
      end
      if (w.alu.wr_en) m_rf[w.alu.dst] = wr;
      m_flags = '{zero: (wr == 16'h0), carry: cy};
    end
    if (trap_now) begin
      upc = 8'hff;                               // Trap vector wins over stop
    end else if (w.jmp.fmt) begin
      if (w.jmp.cond == cond_stop) return n;
      ok = (w.jmp.cond == cond_always) || (w.jmp.cond == cond_zero && m_flags.zero) ||
           (w.jmp.cond == cond_nzero && !m_flags.zero) ||
           (w.jmp.cond == cond_carry && m_flags.carry);
      upc = ok ? w.jmp.target[7:0] : upc + 8'd1;
    end else begin
      upc = upc + 8'd1;
    end
  end
  return n;
endfunction

`endif

// File: tb_cpu.sv
/*
  Testbench for the CPU slice. Loads microprograms through the control
  store port, starts them with fetch and compares CD, ppn_out and trap
  against the included reference model cycle by cycle.
*/
`timescale 1ns/1ps

module tb_cpu
  import nd_cs_pkg::*;
  import nd_bus_pkg::*;
;

  logic       sysclk = 1'b0;
  logic       arst_n;
  logic       wcs_n;
  logic [7:0] cs_waddr;
  cs_word_t   cs_wdata;
  logic       fetch;
  cpu_word_t  idb_in;
  cpu_word_t  cd_out;
  logic       stoc, lapa, trap, halt;
  pa_t        ppn_out;
  int         errors = 0;
  int         budget = 0;    // Expected run length in cycles
  int         wd_cycles = 0;
  int         cyc = 0;       // Cycles since the last fetch

  `include "tb_cpu_model.svh"

  cpu_top #(.CS_AW(8)) UUT (
    .sysclk(sysclk), .arst_n(arst_n), .wcs_n(wcs_n), .cs_waddr(cs_waddr),
    .cs_wdata(cs_wdata), .fetch(fetch), .idb_in(idb_in), .cd_out(cd_out),
    .stoc(stoc), .ppn_out(ppn_out), .lapa(lapa), .trap(trap), .halt(halt)
  );

  always #20 sysclk = ~sysclk;  // 40 ns period

  task automatic fail_now(input string msg);
    errors++;
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_cd(input cpu_word_t got, input cpu_word_t exp);
    if (got !== exp) fail_now($sformatf("ERROR cd_out got %h expected %h", got, exp));
  endtask

  task automatic check_pa(input pa_t got, input pa_t exp);
    if (got !== exp) fail_now($sformatf("ERROR ppn_out got %h expected %h", got, exp));
  endtask

  task automatic check_lapa(input logic got, input logic exp);
    if (got !== exp) fail_now($sformatf("ERROR lapa got %h expected %h", got, exp));
  endtask

  task automatic check_trap(input logic got, input logic exp);
    if (got !== exp) fail_now($sformatf("ERROR trap got %h expected %h", got, exp));
  endtask

  function automatic cs_word_t alu_w(input alu_op_e op, input logic [2:0] dst, src_a, src_b,
                                     input logic imm_en, input logic [11:0] imm,
                                     input logic wr, st, mp, wp);
    cs_word_t w;
    w = '0;
    w.alu = '{fmt: 1'b0, op: op, dst: dst, src_a: src_a, src_b: src_b, use_imm: imm_en,
              imm: imm, wr_en: wr, stoc: st, map: mp, wpt: wp, spare: 2'b0};
    return w;
  endfunction

  function automatic cs_word_t jmp_w(input cond_e c, input logic [11:0] target);
    cs_word_t w;
    w = '0;
    w.jmp = '{fmt: 1'b1, cond: c, target: target, spare: 16'h0};
    return w;
  endfunction

  task automatic load_word(input logic [7:0] addr, input cs_word_t w);
    @(negedge sysclk);
    wcs_n    = 1'b0;
    cs_waddr = addr;
    cs_wdata = w;
    cs_img[addr] = w;  // Model sees the same store
    @(negedge sysclk);
    wcs_n  = 1'b1;
    budget += 2;
  endtask

  // New idb_in, fetch pulse, wait for halt, then look for missing events
  task automatic run_prog;
    @(negedge sysclk);
    idb_in = cpu_word_t'($urandom);
    budget += model_run(idb_in) + 30;
    fetch = 1'b1;
    @(negedge sysclk);
    fetch = 1'b0;
    while (!halt) @(negedge sysclk);
    repeat (3) @(negedge sysclk);  // Late lapa or trap
    if (cd_q.size() != 0) fail_now("Expected CD words never appeared on cd_out");
    if (pa_q.size() != 0) fail_now("Expected translations never appeared on ppn_out");
    if (trap_q.size() != 0) fail_now("Expected trap never occurred");
  endtask

  // Outputs of the ending cycle are sampled at the rising edge
  initial begin : compare
    logic exp_lapa;
    logic exp_trap;
    forever begin
      @(posedge sysclk);
      cyc = fetch ? 0 : cyc + 1;  // Cycle 1 runs word 0
      if (arst_n) begin
        if (stoc) begin
          if (cd_q.size() == 0) fail_now("cd_out carried a word the model did not predict");
          check_cd(cd_out, cd_q.pop_front());
        end else check_cd(cd_out, '0);
        exp_lapa = (pa_cyc_q.size() != 0) && (pa_cyc_q[0] == cyc);
        check_lapa(lapa, exp_lapa);
        if (exp_lapa) begin
          check_pa(ppn_out, pa_q.pop_front());
          void'(pa_cyc_q.pop_front());
        end else check_pa(ppn_out, '0);
        exp_trap = (trap_q.size() != 0) && (trap_q[0] == cyc);
        check_trap(trap, exp_trap);
        if (exp_trap) void'(trap_q.pop_front());
      end
    end
  end

  initial begin : watchdog
    forever begin
      @(posedge sysclk);
      wd_cycles++;
      if (wd_cycles > budget * 4 + 10) fail_now("Watchdog expired before the tests finished");
    end
  end

  initial begin
    void'($urandom(32'hd5ec));
    arst_n = 1'b0;
    wcs_n = 1'b1;
    cs_waddr = '0;
    cs_wdata = '0;
    fetch = 1'b0;
    idb_in = '0;
    m_flags = '0;
    m_valid = '0;
    budget = 10;
    repeat (10) @(negedge sysclk);
    arst_n = 1'b1;
    // ALU operations on immediates and on the bus word in r0
    load_word(0, alu_w(op_ld_idb, 0, 0, 0, 0, 12'h000, 1, 1, 0, 0));
    load_word(1, alu_w(op_pass_b, 1, 0, 0, 1, 12'h123, 1, 1, 0, 0));
    load_word(2, alu_w(op_add,    2, 0, 0, 1, 12'h0f0, 1, 1, 0, 0));
    load_word(3, alu_w(op_sub,    3, 1, 2, 0, 12'h000, 1, 1, 0, 0));
    load_word(4, alu_w(op_and,    4, 0, 0, 1, 12'hff0, 1, 1, 0, 0));
    load_word(5, alu_w(op_or,     5, 1, 0, 1, 12'h800, 1, 1, 0, 0));
    load_word(6, alu_w(op_xor,    6, 5, 0, 0, 12'h000, 1, 1, 0, 0));
    load_word(7, alu_w(op_shl,    7, 0, 0, 0, 12'h000, 1, 1, 0, 0));
    load_word(8, jmp_w(cond_stop, 0));
    run_prog();
    budget += 20;
    repeat (20) @(negedge sysclk) if (!halt) fail_now("CPU left halt without a fetch");
    run_prog();  // Restart repeats the sequence
    // Countdown loop with carry and zero branches
    load_word(0, alu_w(op_pass_b, 1, 0, 0, 1, 12'h003, 1, 0, 0, 0));
    load_word(1, alu_w(op_sub,    1, 1, 0, 1, 12'h001, 1, 1, 0, 0));
    load_word(2, jmp_w(cond_nzero, 1));
    load_word(3, alu_w(op_sub,    3, 1, 0, 1, 12'h001, 1, 0, 0, 0));
    load_word(4, jmp_w(cond_carry, 6));
    load_word(5, alu_w(op_pass_b, 0, 0, 0, 1, 12'hbad, 0, 1, 0, 0));
    load_word(6, alu_w(op_pass_b, 0, 0, 0, 1, 12'h0c5, 0, 1, 0, 0));
    load_word(7, alu_w(op_and,    4, 1, 0, 1, 12'h000, 1, 0, 0, 0));
    load_word(8, jmp_w(cond_zero, 10));
    load_word(9, alu_w(op_pass_b, 0, 0, 0, 1, 12'hbad, 0, 1, 0, 0));
    load_word(10, jmp_w(cond_stop, 0));
    run_prog();
    // Page table load, translation and page fault with trap handler
    load_word(0, alu_w(op_pass_b, 1, 0, 0, 1, 12'h800, 1, 0, 0, 0));
    for (int i = 1; i <= 4; i++) load_word(i, alu_w(op_shl, 1, 1, 0, 0, 12'h0, 1, 0, 0, 0));
    load_word(5, alu_w(op_or,     1, 1, 0, 1, 12'h155, 1, 0, 0, 0));  // Valid entry for ppn 155
    load_word(6, alu_w(op_pass_b, 2, 0, 0, 1, 12'ha55, 1, 0, 0, 0));  // Page 2
    load_word(7, alu_w(op_pass_b, 0, 2, 1, 0, 12'h000, 0, 0, 0, 1));
    load_word(8, alu_w(op_pass_b, 0, 2, 0, 1, 12'h000, 0, 0, 1, 0));
    load_word(9, alu_w(op_pass_b, 0, 0, 0, 1, 12'h000, 0, 0, 0, 0));
    load_word(10, alu_w(op_pass_b, 3, 0, 0, 1, 12'hc12, 1, 0, 0, 0)); // Page 3 is invalid
    load_word(11, alu_w(op_pass_b, 0, 3, 0, 1, 12'h000, 0, 0, 1, 0));
    load_word(12, alu_w(op_pass_b, 0, 0, 0, 1, 12'h111, 0, 1, 0, 0));
    load_word(13, jmp_w(cond_stop, 0));
    load_word(8'hff, jmp_w(cond_always, 200));
    load_word(200, alu_w(op_pass_b, 0, 0, 0, 1, 12'hace, 0, 1, 0, 0)); // Fault marker
    load_word(201, jmp_w(cond_stop, 0));
    run_prog();
    // Rewrite one word so the second map hits the valid page
    load_word(10, alu_w(op_pass_b, 3, 0, 0, 1, 12'h812, 1, 0, 0, 0));
    run_prog();
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
